//--- common/hmem_defs.svh
/*
 * Host memory mapper sizes
 * Line and address widths, burst limits and reorder depth shared by
 * the accelerator side, the host side and the reorder buffer
 */

`ifndef HMEM_DEFS_SVH
`define HMEM_DEFS_SVH

// One cache line of payload
`define HMEM_LINE_BITS 64
// Line address, so no byte offset bits
`define HMEM_ADDR_BITS 16

// Accelerator bursts carry length minus one, up to 16 lines
`define HMEM_AFU_LEN_BITS 4

// Largest host burst, which is also the natural alignment boundary
`define HMEM_HOST_MAX_LINES 4
`define HMEM_HOST_LEN_BITS 2

// Reorder slots and the index that addresses them
`define HMEM_ROB_LINES 16
`define HMEM_ROB_IDX_BITS 4

`define HMEM_ID_BITS 4

`endif

//--- common/hmem_pkg.sv
/*
 * Host memory mapper types
 * Width typedefs and the request, tag and response structs used
 * between the accelerator port, the mapper blocks and the host port
 */

`include "hmem_defs.svh"

package hmem_pkg;

    typedef logic [`HMEM_LINE_BITS-1:0]    line_t;
    typedef logic [`HMEM_ADDR_BITS-1:0]    addr_t;
    typedef logic [`HMEM_AFU_LEN_BITS-1:0] afu_len_t;
    typedef logic [`HMEM_HOST_LEN_BITS-1:0] host_len_t;
    typedef logic [`HMEM_ROB_IDX_BITS-1:0] rob_idx_t;
    typedef logic [`HMEM_ID_BITS-1:0]      id_t;

    // Accelerator read burst, length is lines minus one
    typedef struct packed {
        addr_t    addr;
        afu_len_t len;
        id_t      id;
    } afu_rd_req_t;

    // Accelerator single-line write
    typedef struct packed {
        addr_t addr;
        line_t data;
        id_t   id;
    } afu_wr_req_t;

    // Travels with each host request and comes back on every response line
    typedef struct packed {
        rob_idx_t rob_idx;
        id_t      id;
        logic     afu_last;
    } hmem_tag_t;

    // Both reads and writes use this form on the host request bus
    typedef struct packed {
        logic      is_write;
        addr_t     addr;
        host_len_t len;
        hmem_tag_t tag;
        line_t     data;
    } host_req_t;

    // One host read line, slot is the base slot plus the beat number
    typedef struct packed {
        rob_idx_t  slot;
        hmem_tag_t tag;
        line_t     data;
    } host_rd_rsp_t;

    typedef struct packed {
        id_t   id;
        line_t data;
        logic  last;
    } afu_rd_rsp_t;

    typedef enum logic {
        IDLE,
        ISSUE
    } split_state_t;

endpackage

//--- hmem_map/burst_splitter.sv
/*
 * Burst splitter
 * Breaks an accelerator read burst into host bursts of at most four
 * lines that never cross a four-line boundary
 */

`timescale 1ns/100ps

`include "hmem_defs.svh"

module burst_splitter
(
    input  logic                 clk,
    input  logic                 rst,

    input  hmem_pkg::afu_rd_req_t afu_req,
    input  logic                 afu_req_valid,
    output logic                 afu_req_ready,

    output hmem_pkg::host_req_t  piece,
    output logic                 piece_valid,
    input  logic                 piece_ready
);

    // Line counts run up to 16, one bit wider than the length field
    typedef logic [`HMEM_AFU_LEN_BITS:0] cnt_t;

    hmem_pkg::split_state_t state;

    // Address and count of what is still left after the current piece
    hmem_pkg::addr_t cur_addr;
    cnt_t            lines_left;
    hmem_pkg::id_t   cur_id;

    hmem_pkg::host_req_t piece_r;

    // Source of the next piece, either a fresh burst or the remainder
    hmem_pkg::addr_t src_addr;
    cnt_t            src_left;
    hmem_pkg::id_t   src_id;
    cnt_t            room;
    cnt_t            take;
    logic            load_piece;

    always_comb
    begin
        if (state == hmem_pkg::IDLE)
        begin
            src_addr = afu_req.addr;
            src_left = cnt_t'(afu_req.len) + 1'b1;
            src_id   = afu_req.id;
        end
        else
        begin
            src_addr = cur_addr;
            src_left = lines_left;
            src_id   = cur_id;
        end

        // Lines up to the next alignment boundary
        room = cnt_t'(`HMEM_HOST_MAX_LINES) - cnt_t'(src_addr[`HMEM_HOST_LEN_BITS-1:0]);
        take = (src_left < room) ? src_left : room;
    end

    // A new piece is built when a burst arrives or when the current one is taken
    // and more lines remain
    assign load_piece = ((state == hmem_pkg::IDLE) && afu_req_valid) ||
                        ((state == hmem_pkg::ISSUE) && piece_ready && !piece_r.tag.afu_last);

    always_ff @(posedge clk)
    begin
        if (load_piece)
        begin
            piece_r.is_write     <= 1'b0;
            piece_r.addr         <= src_addr;
            piece_r.len          <= hmem_pkg::host_len_t'(take - 1'b1);
            // The credit gate fills in the slot later
            piece_r.tag.rob_idx  <= '0;
            piece_r.tag.id       <= src_id;
            piece_r.tag.afu_last <= (src_left == take);
            piece_r.data         <= '0;

            cur_addr   <= src_addr + hmem_pkg::addr_t'(take);
            lines_left <= src_left - take;
            cur_id     <= src_id;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= hmem_pkg::IDLE;
        end
        else
        begin
            case (state)
                hmem_pkg::IDLE:
                begin
                    if (afu_req_valid)
                    begin
                        state <= hmem_pkg::ISSUE;
                    end
                end
                hmem_pkg::ISSUE:
                begin
                    // Back to idle once the final piece is gone
                    if (piece_ready && piece_r.tag.afu_last)
                    begin
                        state <= hmem_pkg::IDLE;
                    end
                end
                default:
                begin
                    state <= hmem_pkg::IDLE;
                end
            endcase
        end
    end

    assign piece       = piece_r;
    assign piece_valid = (state == hmem_pkg::ISSUE);

    // The accelerator request was held the whole time, retire it with the last piece
    assign afu_req_ready = (state == hmem_pkg::ISSUE) && piece_ready && piece_r.tag.afu_last;

endmodule

//--- hmem_map/rsp_credit_gate.sv
/*
 * Response credit gate
 * Reserves consecutive reorder slots for each host read burst and
 * holds a piece back until enough slots are free
 */

`timescale 1ns/100ps

`include "hmem_defs.svh"

module rsp_credit_gate
(
    input  logic                clk,
    input  logic                rst,

    input  hmem_pkg::host_req_t piece_in,
    input  logic                piece_in_valid,
    output logic                piece_in_ready,

    output hmem_pkg::host_req_t rd_req,
    output logic                rd_req_valid,
    input  logic                rd_req_ready,

    input  logic                rob_release
);

    // Free count spans 0 to 16
    typedef logic [`HMEM_ROB_IDX_BITS:0] cnt_t;

    hmem_pkg::rob_idx_t alloc_ptr;
    cnt_t               free_cnt;
    cnt_t               need;
    cnt_t               spent;
    logic               fits;
    logic               take;

    assign need = cnt_t'(piece_in.len) + 1'b1;
    assign fits = (free_cnt >= need);

    // The host returns lines with no flow control, so a piece only goes out
    // with every one of its slots already reserved
    always_comb
    begin
        rd_req             = piece_in;
        rd_req.tag.rob_idx = alloc_ptr;
    end

    assign rd_req_valid   = piece_in_valid && fits;
    assign piece_in_ready = rd_req_ready && fits;
    assign take           = rd_req_valid && rd_req_ready;

    assign spent = take ? need : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alloc_ptr <= '0;
            free_cnt  <= cnt_t'(`HMEM_ROB_LINES);
        end
        else
        begin
            // Slots are handed out in order and the pointer wraps with the ring
            if (take)
            begin
                alloc_ptr <= alloc_ptr + hmem_pkg::rob_idx_t'(need);
            end
            free_cnt <= free_cnt - spent + cnt_t'(rob_release);
        end
    end

endmodule

//--- hmem_map/read_rob.sv
/*
 * Read reorder buffer
 * Stores host read lines by slot as they arrive in any order and
 * hands them to the accelerator in request order
 */

`timescale 1ns/100ps

`include "hmem_defs.svh"

module read_rob
(
    input  logic                   clk,
    input  logic                   rst,

    input  hmem_pkg::host_rd_rsp_t host_rd_rsp,
    input  logic                   host_rd_rsp_valid,

    output hmem_pkg::afu_rd_rsp_t  afu_rd_rsp,
    output logic                   afu_rd_rsp_valid,
    input  logic                   afu_rd_rsp_ready,

    output logic                   rob_release
);

    // Per slot storage
    hmem_pkg::line_t slot_data [`HMEM_ROB_LINES];
    hmem_pkg::id_t   slot_id   [`HMEM_ROB_LINES];
    logic            slot_last [`HMEM_ROB_LINES];

    // Marks which slots hold a line not yet delivered
    logic [`HMEM_ROB_LINES-1:0] slot_valid;

    // Oldest slot still owed to the accelerator
    hmem_pkg::rob_idx_t head;

    logic deliver;

    // Payload of each slot, written as the host line arrives
    always_ff @(posedge clk)
    begin
        if (host_rd_rsp_valid)
        begin
            slot_data[host_rd_rsp.slot] <= host_rd_rsp.data;
            slot_id[host_rd_rsp.slot]   <= host_rd_rsp.tag.id;
            // The host sets afu_last only on the final line of the burst
            slot_last[host_rd_rsp.slot] <= host_rd_rsp.tag.afu_last;
        end
    end

    assign afu_rd_rsp_valid = slot_valid[head];
    assign afu_rd_rsp.id    = slot_id[head];
    assign afu_rd_rsp.data  = slot_data[head];
    assign afu_rd_rsp.last  = slot_last[head];

    assign deliver     = afu_rd_rsp_valid && afu_rd_rsp_ready;
    assign rob_release = deliver;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slot_valid <= '0;
            head       <= '0;
        end
        else
        begin
            // An arriving line never targets the head while the head is valid,
            // since the credit gate keeps live slots from being reused
            if (host_rd_rsp_valid)
            begin
                slot_valid[host_rd_rsp.slot] <= 1'b1;
            end

            if (deliver)
            begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
        end
    end

endmodule

//--- verilog/host_req_arbiter.sv
/*
 * Host request arbiter
 * Round-robin choice between read pieces and single-line writes for
 * the one host request bus
 */

`timescale 1ns/100ps

module host_req_arbiter
(
    input  logic                  clk,
    input  logic                  rst,

    input  hmem_pkg::host_req_t   rd_req,
    input  logic                  rd_req_valid,
    output logic                  rd_req_ready,

    input  hmem_pkg::afu_wr_req_t wr_req,
    input  logic                  wr_req_valid,
    output logic                  wr_req_ready,

    output hmem_pkg::host_req_t   host_req,
    output logic                  host_req_valid,
    input  logic                  host_req_ready
);

    // Set when the read side won the most recent transfer
    logic last_rd;

    logic grant_rd;
    logic grant_wr;

    hmem_pkg::host_req_t wr_form;

    // With both valid the side that did not win last time goes first
    assign grant_rd = rd_req_valid && (!wr_req_valid || !last_rd);
    assign grant_wr = wr_req_valid && !grant_rd;

    always_comb
    begin
        wr_form.is_write     = 1'b1;
        wr_form.addr         = wr_req.addr;
        wr_form.len          = '0;
        wr_form.tag.rob_idx  = '0;
        wr_form.tag.id       = wr_req.id;
        wr_form.tag.afu_last = 1'b0;
        wr_form.data         = wr_req.data;
    end

    assign host_req       = grant_rd ? rd_req : wr_form;
    assign host_req_valid = rd_req_valid || wr_req_valid;

    // The loser never sees ready and keeps its request
    assign rd_req_ready = grant_rd && host_req_ready;
    assign wr_req_ready = grant_wr && host_req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last_rd <= 1'b0;
        end
        else if (host_req_valid && host_req_ready)
        begin
            last_rd <= grant_rd;
        end
    end

endmodule

//--- verilog/hmem_map_top.sv
/*
 * Host memory mapper
 * Splits, credits, arbitrates and reorders accelerator memory traffic
 * onto a single host memory port
 */

`timescale 1ns/100ps

module hmem_map_top
(
    input  logic                   clk,
    input  logic                   rst,

    // Accelerator side
    input  hmem_pkg::afu_rd_req_t  afu_rd_req,
    input  logic                   afu_rd_req_valid,
    output logic                   afu_rd_req_ready,
    input  hmem_pkg::afu_wr_req_t  afu_wr_req,
    input  logic                   afu_wr_req_valid,
    output logic                   afu_wr_req_ready,
    output hmem_pkg::afu_rd_rsp_t  afu_rd_rsp,
    output logic                   afu_rd_rsp_valid,
    input  logic                   afu_rd_rsp_ready,
    output hmem_pkg::id_t          afu_wr_ack,
    output logic                   afu_wr_ack_valid,

    // Host side
    output hmem_pkg::host_req_t    host_req,
    output logic                   host_req_valid,
    input  logic                   host_req_ready,
    input  hmem_pkg::host_rd_rsp_t host_rd_rsp,
    input  logic                   host_rd_rsp_valid,
    input  hmem_pkg::id_t          host_wr_ack,
    input  logic                   host_wr_ack_valid
);

    // Aligned pieces from the splitter, before slots are stamped
    hmem_pkg::host_req_t piece;
    logic                piece_valid;
    logic                piece_ready;

    // Credited read requests toward the arbiter
    hmem_pkg::host_req_t rd_req;
    logic                rd_req_valid;
    logic                rd_req_ready;

    logic rob_release;

    burst_splitter u_splitter
    (
        .clk           (clk),
        .rst           (rst),
        .afu_req       (afu_rd_req),
        .afu_req_valid (afu_rd_req_valid),
        .afu_req_ready (afu_rd_req_ready),
        .piece         (piece),
        .piece_valid   (piece_valid),
        .piece_ready   (piece_ready)
    );

    rsp_credit_gate u_credit
    (
        .clk            (clk),
        .rst            (rst),
        .piece_in       (piece),
        .piece_in_valid (piece_valid),
        .piece_in_ready (piece_ready),
        .rd_req         (rd_req),
        .rd_req_valid   (rd_req_valid),
        .rd_req_ready   (rd_req_ready),
        .rob_release    (rob_release)
    );

    host_req_arbiter u_arb
    (
        .clk            (clk),
        .rst            (rst),
        .rd_req         (rd_req),
        .rd_req_valid   (rd_req_valid),
        .rd_req_ready   (rd_req_ready),
        .wr_req         (afu_wr_req),
        .wr_req_valid   (afu_wr_req_valid),
        .wr_req_ready   (afu_wr_req_ready),
        .host_req       (host_req),
        .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready)
    );

    read_rob u_rob
    (
        .clk               (clk),
        .rst               (rst),
        .host_rd_rsp       (host_rd_rsp),
        .host_rd_rsp_valid (host_rd_rsp_valid),
        .afu_rd_rsp        (afu_rd_rsp),
        .afu_rd_rsp_valid  (afu_rd_rsp_valid),
        .afu_rd_rsp_ready  (afu_rd_rsp_ready),
        .rob_release       (rob_release)
    );

    // Write acks need no ordering and go straight back
    assign afu_wr_ack       = host_wr_ack;
    assign afu_wr_ack_valid = host_wr_ack_valid;

endmodule

//--- bench/hmem_checker.sv
/*
 * Host memory mapper checker
 * Watches the DUT ports, keeps a reference memory and checks read data,
 * burst splitting, credit limits, write acks and arbiter fairness
 */

`timescale 1ns/100ps

`include "hmem_defs.svh"

module hmem_checker
(
    input  logic                   clk,
    input  logic                   rst,
    input  hmem_pkg::afu_rd_req_t  afu_rd_req,
    input  logic                   afu_rd_req_valid,
    input  hmem_pkg::afu_wr_req_t  afu_wr_req,
    input  logic                   afu_wr_req_valid,
    input  logic                   afu_wr_req_ready,
    input  hmem_pkg::afu_rd_rsp_t  afu_rd_rsp,
    input  logic                   afu_rd_rsp_valid,
    input  logic                   afu_rd_rsp_ready,
    input  hmem_pkg::id_t          afu_wr_ack,
    input  logic                   afu_wr_ack_valid,
    input  hmem_pkg::host_req_t    host_req,
    input  logic                   host_req_valid,
    input  logic                   host_req_ready,
    // Credited read request waiting inside the DUT
    input  logic                   rd_pend,
    output int                     error_count,
    output logic                   idle
);

    hmem_pkg::line_t       ref_mem [0:65535];
    hmem_pkg::afu_rd_rsp_t exp_q [$];
    hmem_pkg::id_t         ack_q [$];

    int   lines_in;
    int   lines_out;
    // Lines of the current accelerator burst already seen on the host bus
    int   piece_off;
    logic last_win_wr;
    logic have_win;

    // Every bit of the address shows up somewhere in the line
    function automatic hmem_pkg::line_t line_pattern(input hmem_pkg::addr_t a);
        return {a ^ 16'hc3a5, ~a, a[7:0], a[15:8], a + 16'h1357};
    endfunction

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
        $display("Fail %s expected %h actual %h", name, exp, act);
        error_count++;
    endtask

    task automatic report_rule(input string msg);
        $display("Error: %s", msg);
        error_count++;
    endtask

    initial
    begin
        for (int i = 0; i < 65536; i++)
        begin
            ref_mem[i] = line_pattern(hmem_pkg::addr_t'(i));
        end
    end

    always @(posedge clk)
    begin
        hmem_pkg::afu_rd_rsp_t exp;
        hmem_pkg::addr_t       a;
        hmem_pkg::id_t         ack_exp;
        int                    n;
        int                    burst;

        if (rst)
        begin
            error_count = 0;
            lines_in    = 0;
            lines_out   = 0;
            piece_off   = 0;
            have_win    = 1'b0;
            last_win_wr = 1'b0;
            idle       <= 1'b1;
        end
        else
        begin
            // An accepted write is already at the host, so later reads see it
            if (afu_wr_req_valid && afu_wr_req_ready)
            begin
                ref_mem[afu_wr_req.addr] = afu_wr_req.data;
                ack_q.push_back(afu_wr_req.id);
            end

            if (host_req_valid && host_req_ready)
            begin
                if (have_win && rd_pend && afu_wr_req_valid && host_req.is_write == last_win_wr)
                begin
                    report_rule("arbiter granted one requester twice while the other waited");
                end
                last_win_wr = host_req.is_write;
                have_win    = 1'b1;

                if (!host_req.is_write)
                begin
                    n     = int'(host_req.len) + 1;
                    burst = int'(afu_rd_req.len) + 1;
                    if (int'(host_req.addr[1:0]) + n > `HMEM_HOST_MAX_LINES)
                    begin
                        report_rule("host read burst crosses a four-line boundary");
                    end
                    if (!afu_rd_req_valid)
                    begin
                        report_rule("host read issued with no accelerator read pending");
                    end
                    else
                    begin
                        a = afu_rd_req.addr + hmem_pkg::addr_t'(piece_off);
                        if (host_req.addr !== a)
                        begin
                            report_value("piece_addr", 128'(a), 128'(host_req.addr));
                        end
                        if (host_req.tag.id !== afu_rd_req.id)
                        begin
                            report_value("piece_id", 128'(afu_rd_req.id), 128'(host_req.tag.id));
                        end
                        // Each piece books its lines in request order with the data
                        // the host memory holds when the piece goes out
                        for (int b = 0; b < n; b++)
                        begin
                            exp.id   = afu_rd_req.id;
                            exp.data = ref_mem[a + hmem_pkg::addr_t'(b)];
                            exp.last = (piece_off + b == burst - 1);
                            exp_q.push_back(exp);
                        end
                        piece_off += n;
                        if (host_req.tag.afu_last)
                        begin
                            if (piece_off != burst)
                            begin
                                report_value("burst_lines", 128'(burst), 128'(piece_off));
                            end
                            piece_off = 0;
                        end
                        else if (piece_off >= burst)
                        begin
                            report_rule("pieces cover the burst but none is marked final");
                        end
                    end
                    lines_in += n;
                end
            end

            if (afu_rd_rsp_valid && afu_rd_rsp_ready)
            begin
                lines_out++;
                if (exp_q.size() == 0)
                begin
                    report_rule("read line delivered when none was owed");
                end
                else
                begin
                    exp = exp_q.pop_front();
                    if (afu_rd_rsp !== exp)
                    begin
                        report_value("read_line", 128'(exp), 128'(afu_rd_rsp));
                    end
                end
            end

            if (afu_wr_ack_valid)
            begin
                if (ack_q.size() == 0)
                begin
                    report_rule("write ack with no write outstanding");
                end
                else
                begin
                    ack_exp = ack_q.pop_front();
                    if (afu_wr_ack !== ack_exp)
                    begin
                        report_value("write_ack_id", 128'(ack_exp), 128'(afu_wr_ack));
                    end
                end
            end

            if (lines_in - lines_out > `HMEM_ROB_LINES)
            begin
                report_rule("more read lines outstanding than reorder slots");
            end

            idle <= (exp_q.size() == 0) && (ack_q.size() == 0);
        end
    end

endmodule

//--- bench/hmem_tb.sv
/*
 * Host memory mapper testbench
 * Replays the vector list on the accelerator side and models a host
 * that answers reads out of order after random delays
 */

`timescale 1ns/100ps

module hmem_tb;

    logic clk = 1'b0;
    logic rst = 1'b1;

    hmem_pkg::afu_rd_req_t  afu_rd_req;
    logic                   afu_rd_req_valid;
    logic                   afu_rd_req_ready;
    hmem_pkg::afu_wr_req_t  afu_wr_req;
    logic                   afu_wr_req_valid;
    logic                   afu_wr_req_ready;
    hmem_pkg::afu_rd_rsp_t  afu_rd_rsp;
    logic                   afu_rd_rsp_valid;
    logic                   afu_rd_rsp_ready;
    hmem_pkg::id_t          afu_wr_ack;
    logic                   afu_wr_ack_valid;
    hmem_pkg::host_req_t    host_req;
    logic                   host_req_valid;
    logic                   host_req_ready;
    hmem_pkg::host_rd_rsp_t host_rd_rsp;
    logic                   host_rd_rsp_valid;
    hmem_pkg::id_t          host_wr_ack;
    logic                   host_wr_ack_valid;

    int   error_count;
    logic idle;

    // Five words per vector as listed in the column line of the file
    logic [63:0] vec_mem [0:319];
    int          num_vec;
    int          num_rd;
    int          num_wr;
    int          cycle = 0;
    int          limit;

    logic [31:0]            rng = 32'h478c;
    hmem_pkg::line_t        host_mem [0:65535];
    hmem_pkg::host_rd_rsp_t pend_rsp [$];
    int                     pend_due [$];
    hmem_pkg::id_t          ack_id [$];
    int                     ack_due [$];

    always #2 clk = ~clk;

    hmem_map_top u_dut
    (
        .clk (clk), .rst (rst),
        .afu_rd_req (afu_rd_req), .afu_rd_req_valid (afu_rd_req_valid),
        .afu_rd_req_ready (afu_rd_req_ready),
        .afu_wr_req (afu_wr_req), .afu_wr_req_valid (afu_wr_req_valid),
        .afu_wr_req_ready (afu_wr_req_ready),
        .afu_rd_rsp (afu_rd_rsp), .afu_rd_rsp_valid (afu_rd_rsp_valid),
        .afu_rd_rsp_ready (afu_rd_rsp_ready),
        .afu_wr_ack (afu_wr_ack), .afu_wr_ack_valid (afu_wr_ack_valid),
        .host_req (host_req), .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .host_rd_rsp (host_rd_rsp), .host_rd_rsp_valid (host_rd_rsp_valid),
        .host_wr_ack (host_wr_ack), .host_wr_ack_valid (host_wr_ack_valid)
    );

    hmem_checker u_chk
    (
        .clk (clk), .rst (rst),
        .afu_rd_req (afu_rd_req), .afu_rd_req_valid (afu_rd_req_valid),
        .afu_wr_req (afu_wr_req), .afu_wr_req_valid (afu_wr_req_valid),
        .afu_wr_req_ready (afu_wr_req_ready),
        .afu_rd_rsp (afu_rd_rsp), .afu_rd_rsp_valid (afu_rd_rsp_valid),
        .afu_rd_rsp_ready (afu_rd_rsp_ready),
        .afu_wr_ack (afu_wr_ack), .afu_wr_ack_valid (afu_wr_ack_valid),
        .host_req (host_req), .host_req_valid (host_req_valid),
        .host_req_ready (host_req_ready),
        .rd_pend (u_dut.rd_req_valid),
        .error_count (error_count), .idle (idle)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Host memory starts from the same address pattern as the reference
    function automatic hmem_pkg::line_t line_pattern(input hmem_pkg::addr_t a);
        return {a ^ 16'hc3a5, ~a, a[7:0], a[15:8], a + 16'h1357};
    endfunction

    // Holds valid from one falling edge until ready is seen on a rising edge
    task automatic issue_op(input int v);
        logic done;
        logic is_wr;

        done  = 1'b0;
        is_wr = vec_mem[5*v][0];
        @(negedge clk);
        if (is_wr)
        begin
            afu_wr_req.addr  = vec_mem[5*v+1][15:0];
            afu_wr_req.id    = vec_mem[5*v+3][3:0];
            afu_wr_req.data  = vec_mem[5*v+4];
            afu_wr_req_valid = 1'b1;
            num_wr++;
        end
        else
        begin
            afu_rd_req.addr  = vec_mem[5*v+1][15:0];
            afu_rd_req.len   = vec_mem[5*v+2][3:0];
            afu_rd_req.id    = vec_mem[5*v+3][3:0];
            afu_rd_req_valid = 1'b1;
            num_rd++;
        end
        while (!done)
        begin
            @(posedge clk);
            if (is_wr)
            begin
                done = afu_wr_req_valid && afu_wr_req_ready;
            end
            else
            begin
                done = afu_rd_req_valid && afu_rd_req_ready;
            end
        end
        @(negedge clk);
        if (is_wr)
        begin
            afu_wr_req_valid = 1'b0;
        end
        else
        begin
            afu_rd_req_valid = 1'b0;
        end
    endtask

    // Host side takes requests on the rising edge
    always @(posedge clk)
    begin
        hmem_pkg::host_rd_rsp_t r;

        if (!rst && host_req_valid && host_req_ready)
        begin
            if (host_req.is_write)
            begin
                host_mem[host_req.addr] = host_req.data;
                rng = xorshift(rng);
                ack_id.push_back(host_req.tag.id);
                ack_due.push_back(cycle + 1 + int'(rng[2:0]));
            end
            else
            begin
                for (int b = 0; b <= int'(host_req.len); b++)
                begin
                    rng = xorshift(rng);
                    r.slot         = host_req.tag.rob_idx + hmem_pkg::rob_idx_t'(b);
                    r.tag          = host_req.tag;
                    r.tag.afu_last = host_req.tag.afu_last && (b == int'(host_req.len));
                    r.data         = host_mem[host_req.addr + hmem_pkg::addr_t'(b)];
                    pend_rsp.push_back(r);
                    pend_due.push_back(cycle + 2 + int'(rng[3:0]));
                end
            end
        end
    end

    // Host answers and random ready on the falling edge
    always @(negedge clk)
    begin
        int idx;

        rng               = xorshift(rng);
        host_req_ready    = rng[0] | rng[1];
        afu_rd_rsp_ready  = rng[2] | rng[3];
        host_rd_rsp_valid = 1'b0;
        host_wr_ack_valid = 1'b0;
        if (pend_rsp.size() > 0)
        begin
            idx = int'(rng[23:8]) % pend_rsp.size();
            if (pend_due[idx] <= cycle)
            begin
                host_rd_rsp       = pend_rsp[idx];
                host_rd_rsp_valid = 1'b1;
                pend_rsp.delete(idx);
                pend_due.delete(idx);
            end
        end
        if (ack_id.size() > 0 && ack_due[0] <= cycle)
        begin
            host_wr_ack       = ack_id.pop_front();
            host_wr_ack_valid = 1'b1;
            ack_due.delete(0);
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= limit)
        begin
            $display("Timeout: run still busy after %0d cycles", limit);
            $display("Errors: %0d, reads: %0d, writes: %0d", error_count, num_rd, num_wr);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        afu_rd_req        = '0;
        afu_rd_req_valid  = 1'b0;
        afu_wr_req        = '0;
        afu_wr_req_valid  = 1'b0;
        afu_rd_rsp_ready  = 1'b0;
        host_req_ready    = 1'b0;
        host_rd_rsp       = '0;
        host_rd_rsp_valid = 1'b0;
        host_wr_ack       = '0;
        host_wr_ack_valid = 1'b0;
        limit  = 100000;
        num_rd = 0;
        num_wr = 0;

        for (int i = 0; i < 65536; i++)
        begin
            host_mem[i] = line_pattern(hmem_pkg::addr_t'(i));
        end
        $readmemh("bench/hmem_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < 64 && vec_mem[5*num_vec][3:0] != 4'hf)
        begin
            num_vec++;
        end
        limit = 200 + 40 * num_vec;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reads and writes run as two streams so both requesters compete for the host bus
        fork
            begin
                for (int v = 0; v < num_vec; v++)
                begin
                    if (!vec_mem[5*v][0])
                    begin
                        issue_op(v);
                    end
                end
            end
            begin
                for (int v = 0; v < num_vec; v++)
                begin
                    if (vec_mem[5*v][0])
                    begin
                        issue_op(v);
                    end
                end
            end
        join
        // The checker reports idle once every owed line and ack has come back
        repeat (2) @(posedge clk);
        while (!idle)
        begin
            @(posedge clk);
        end

        $display("Errors: %0d, reads: %0d, writes: %0d", error_count, num_rd, num_wr);
        if (error_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bench/hmem_vectors.txt
// Columns: kind (0 read, 1 write, f end of list), line address, length minus one, id, write data
// Reads ignore the data column and writes ignore the length column
0 0010 3 1 0
0 0013 f 2 0
1 0020 0 3 1122334455667788
0 001e 5 4 0
0 0101 6 5 0
1 0102 0 6 a5a5a5a5deadbeef
1 0103 0 7 0123456789abcdef
0 0100 7 8 0
0 0200 f 9 0
0 0204 f a 0
0 0202 1 b 0
1 0300 0 c fedcba9876543210
0 02ff 2 d 0
0 0300 0 e 0
f 0 0 0 0

//--- build.f
+incdir+common
common/hmem_pkg.sv
hmem_map/burst_splitter.sv
hmem_map/rsp_credit_gate.sv
hmem_map/read_rob.sv
verilog/host_req_arbiter.sv
verilog/hmem_map_top.sv
bench/hmem_checker.sv
bench/hmem_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = hmem_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
